// File: hw/seqmon_pkg.sv
`default_nettype none

package seqmon_pkg;

   //--------------------------------------------------
   // frame format
   //--------------------------------------------------

   // byte 3 of every frame carries the fixed protocol tag
   localparam int unsigned hdr_a_pos = 3;
   localparam logic [7:0]  hdr_a_val = 8'h01;

   // byte 4 carries the fixed message type
   localparam int unsigned hdr_b_pos = 4;
   localparam logic [7:0]  hdr_b_val = 8'h70;

   // one report per finished frame, valid is a single-cycle strobe
   typedef struct packed {
      logic [23:0] index;
      logic        header_ok;
      logic        valid;
   } frame_result_t;

   typedef struct packed {
      logic        started;
      logic        finished;
      logic [31:0] frames;
      logic [31:0] seq_ok;
      logic [31:0] seq_err;
      logic [31:0] hdr_err;
   } stats_t;

   //--------------------------------------------------
   // register map (byte offsets)
   //--------------------------------------------------

   localparam logic [7:0] reg_ctrl    = 8'h00;
   localparam logic [7:0] reg_status  = 8'h04;
   localparam logic [7:0] reg_frames  = 8'h08;
   localparam logic [7:0] reg_seq_ok  = 8'h0C;
   localparam logic [7:0] reg_seq_err = 8'h10;
   localparam logic [7:0] reg_hdr_err = 8'h14;

endpackage

`default_nettype wire

// File: hw/frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module frame_parser #(
   parameter int unsigned index_offset = 13
) (
   input  wire                       clk125MHz,
   input  wire                       rst,
   input  wire                       rx_en,
   input  wire [7:0]                 rx_data,
   output seqmon_pkg::frame_result_t frame
);

   import seqmon_pkg::*;

   // byte positions as counter-width constants
   localparam logic [15:0] pos_a     = 16'(hdr_a_pos);
   localparam logic [15:0] pos_b     = 16'(hdr_b_pos);
   localparam logic [15:0] pos_first = 16'(index_offset);
   localparam logic [15:0] pos_last  = 16'(index_offset + 2);

   // a frame is long enough once both the index and the header bytes have passed
   localparam logic [15:0] pos_need  = (pos_last > pos_b) ? pos_last : pos_b;

   logic [15:0] pos;
   logic        rx_en_q;
   logic        hdr_ok;
   logic        len_ok;
   logic        frame_end;
   logic [23:0] idx;
   logic [23:0] idx_q;
   logic        header_ok_q;
   logic        valid_q;

   assign frame_end = rx_en_q && !rx_en;

   //--------------------------------------------------
   // byte position and header tracking
   //--------------------------------------------------

   always_ff @(posedge clk125MHz) begin
      if (rst) begin
         pos     <= '0;
         rx_en_q <= 1'b0;
         hdr_ok  <= 1'b0;
         len_ok  <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         rx_en_q <= rx_en;
         valid_q <= frame_end;
         if (rx_en) begin
            // saturate so an oversized frame never wraps back onto the header
            if (pos != '1) begin
               pos <= pos + 16'd1;
            end
            if (pos == '0) begin
               hdr_ok <= 1'b1;
               len_ok <= 1'b0;
            end
            if (pos == pos_a && rx_data != hdr_a_val) begin
               hdr_ok <= 1'b0;
            end
            if (pos == pos_b && rx_data != hdr_b_val) begin
               hdr_ok <= 1'b0;
            end
            if (pos == pos_need) begin
               len_ok <= 1'b1;
            end
         end else begin
            pos <= '0;
         end
      end
   end

   //--------------------------------------------------
   // index assembly and frame report
   //--------------------------------------------------

   // the index arrives most significant byte first
   always_ff @(posedge clk125MHz) begin
      if (rx_en && pos >= pos_first && pos <= pos_last) begin
         idx <= {idx[15:0], rx_data};
      end
      if (frame_end) begin
         idx_q       <= idx;
         header_ok_q <= hdr_ok && len_ok;
      end
   end

   assign frame.index     = idx_q;
   assign frame.header_ok = header_ok_q;
   assign frame.valid     = valid_q;

   // every frame ends with at least one idle cycle, so reports never touch
   a_single_report: assert property (
      @(posedge clk125MHz) disable iff (rst) frame.valid |=> !frame.valid
   ) else $error("frame_parser: frame reported on two consecutive cycles");

endmodule

`default_nettype wire

// File: hw/seq_checker.sv
`timescale 1ns/1ps
`default_nettype none

module seq_checker #(
   parameter int unsigned index_max = 500000
) (
   input  wire                           clk125MHz,
   input  wire                           rst,
   input  wire seqmon_pkg::frame_result_t frame,
   input  wire                           clear,
   output seqmon_pkg::stats_t            stats
);

   localparam logic [23:0] final_idx = 24'(index_max);

   logic [23:0] prev_idx;
   logic [23:0] next_idx;
   logic        in_order;
   logic        is_final;
   logic        is_zero;

   // an index is in order when it follows the previous one directly
   assign next_idx = prev_idx + 24'd1;
   assign in_order = (frame.index == next_idx);
   assign is_final = (frame.index == final_idx);
   assign is_zero  = (frame.index == 24'd0);

   //--------------------------------------------------
   // run state and statistics
   //--------------------------------------------------

   always_ff @(posedge clk125MHz) begin
      if (rst || clear) begin
         stats    <= '0;
         prev_idx <= '0;
      end else if (frame.valid) begin
         if (!frame.header_ok) begin
            // rejected frames are counted at any point of the run
            stats.hdr_err <= stats.hdr_err + 32'd1;
         end else if (!stats.started) begin
            // the run arms on index 0, earlier frames are ignored
            if (is_zero) begin
               stats.started <= 1'b1;
               prev_idx      <= frame.index;
            end
         end else if (!stats.finished) begin
            stats.frames <= stats.frames + 32'd1;
            if (in_order) begin
               stats.seq_ok <= stats.seq_ok + 32'd1;
            end else begin
               stats.seq_err <= stats.seq_err + 32'd1;
            end
            prev_idx <= frame.index;
            // the last frame still counts, the run closes behind it
            if (is_final) begin
               stats.finished <= 1'b1;
            end
         end
      end
   end

   a_finish_after_start: assert property (
      @(posedge clk125MHz) disable iff (rst) stats.finished |-> stats.started
   ) else $error("seq_checker: finished set without a started run");

endmodule

`default_nettype wire

// File: hw/stats_regs.sv
`timescale 1ns/1ps
`default_nettype none

module stats_regs (
   input  wire                    clk125MHz,
   input  wire                    rst,
   input  wire seqmon_pkg::stats_t stats,
   output logic                   clear,
   input  wire [7:0]              awaddr,
   input  wire                    awvalid,
   output logic                   awready,
   input  wire [31:0]             wdata,
   input  wire                    wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  wire                    bready,
   input  wire [7:0]              araddr,
   input  wire                    arvalid,
   output logic                   arready,
   output logic [31:0]            rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  wire                    rready
);

   import seqmon_pkg::*;

   localparam logic [1:0] resp_okay = 2'b00;

   logic        wr_accept;
   logic        wr_fire;
   logic        rd_fire;
   logic [31:0] rd_word;

   assign bresp = resp_okay;
   assign rresp = resp_okay;

   //--------------------------------------------------
   // read channel
   //--------------------------------------------------

   // one read in flight, a new address waits until the response is taken
   assign arready = !rvalid;
   assign rd_fire = arvalid && arready;

   always_comb begin
      case (araddr)
         reg_status:  rd_word = {30'd0, stats.finished, stats.started};
         reg_frames:  rd_word = stats.frames;
         reg_seq_ok:  rd_word = stats.seq_ok;
         reg_seq_err: rd_word = stats.seq_err;
         reg_hdr_err: rd_word = stats.hdr_err;
         // ctrl reads back as zero, same as any unmapped offset
         default:     rd_word = 32'd0;
      endcase
   end

   always_ff @(posedge clk125MHz) begin
      if (rst) begin
         rvalid <= 1'b0;
      end else if (rd_fire) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   // the word is sampled at the address handshake and held until rready
   always_ff @(posedge clk125MHz) begin
      if (rd_fire) begin
         rdata <= rd_word;
      end
   end

   //--------------------------------------------------
   // write channel
   //--------------------------------------------------

   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign wr_fire = wr_accept && awvalid && wvalid;

   always_ff @(posedge clk125MHz) begin
      if (rst) begin
         wr_accept <= 1'b0;
         bvalid    <= 1'b0;
         clear     <= 1'b0;
      end else begin
         // address and data are taken together once both are presented
         wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
         clear     <= wr_fire && (awaddr == reg_ctrl) && wdata[0];
         if (wr_fire) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   a_read_hold: assert property (
      @(posedge clk125MHz) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata)
   ) else $error("stats_regs: read response changed under back-pressure");

endmodule

`default_nettype wire

// File: hw/seqmon_top.sv
`timescale 1ns/1ps
`default_nettype none

module seqmon_top #(
   parameter int unsigned index_offset = 13,
   parameter int unsigned index_max    = 500000
) (
   input  wire        clk125MHz,
   input  wire        rst,
   input  wire        rx_en,
   input  wire [7:0]  rx_data,
   input  wire [7:0]  awaddr,
   input  wire        awvalid,
   output logic       awready,
   input  wire [31:0] wdata,
   input  wire        wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  wire        bready,
   input  wire [7:0]  araddr,
   input  wire        arvalid,
   output logic       arready,
   output logic [31:0] rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  wire        rready
);

   seqmon_pkg::frame_result_t frame;
   seqmon_pkg::stats_t        stats;
   logic                      clear;

   //--------------------------------------------------
   // parser -> checker -> registers
   //--------------------------------------------------

   frame_parser #(
      .index_offset (index_offset)
   ) i_parser (
      .clk125MHz (clk125MHz),
      .rst       (rst),
      .rx_en     (rx_en),
      .rx_data   (rx_data),
      .frame     (frame)
   );

   seq_checker #(
      .index_max (index_max)
   ) i_checker (
      .clk125MHz (clk125MHz),
      .rst       (rst),
      .frame     (frame),
      .clear     (clear),
      .stats     (stats)
   );

   stats_regs i_regs (
      .clk125MHz (clk125MHz),
      .rst       (rst),
      .stats     (stats),
      .clear     (clear),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready)
   );

endmodule

`default_nettype wire

// File: verif/seqmon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seqmon_tb;

   import seqmon_pkg::*;

   localparam int idx_off       = 13;
   localparam int idx_final     = 6;
   localparam int n_rows        = 13;
   localparam int reads_per_chk = 5;

   // hdr selects 0 for a good header, 1 to corrupt the tag byte, 2 to corrupt the type byte
   typedef struct packed {
      logic [23:0] index;
      logic [1:0]  hdr;
      logic [7:0]  len;
      logic [7:0]  gap;
   } frame_row_t;

   localparam frame_row_t rows [n_rows] = '{
      '{24'd3, 2'd0, 8'd20, 8'd4},
      '{24'd0, 2'd0, 8'd18, 8'd4},
      '{24'd1, 2'd0, 8'd16, 8'd3},
      '{24'd2, 2'd0, 8'd24, 8'd3},
      '{24'd3, 2'd0, 8'd20, 8'd3},
      '{24'd5, 2'd0, 8'd20, 8'd3},
      '{24'd5, 2'd0, 8'd20, 8'd5},
      '{24'd9, 2'd1, 8'd20, 8'd3},
      '{24'd6, 2'd2, 8'd20, 8'd3},
      '{24'd6, 2'd0, 8'd12, 8'd3},
      '{24'd6, 2'd0, 8'd22, 8'd4},
      '{24'd7, 2'd0, 8'd20, 8'd3},
      '{24'd0, 2'd1, 8'd20, 8'd3}
   };

   logic        clk125MHz;
   logic        rst;
   logic        rx_en;
   logic [7:0]  rx_data;
   logic [7:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [7:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   // reference model state
   logic        exp_started;
   logic        exp_finished;
   logic [23:0] exp_prev;
   logic [31:0] exp_frames;
   logic [31:0] exp_seq_ok;
   logic [31:0] exp_seq_err;
   logic [31:0] exp_hdr_err;

   int errors;
   int checks;
   int cycles;
   int cycle_limit;

   seqmon_top #(
      .index_offset (idx_off),
      .index_max    (idx_final)
   ) i_dut (
      .clk125MHz (clk125MHz),
      .rst       (rst),
      .rx_en     (rx_en),
      .rx_data   (rx_data),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready)
   );

   initial begin
      clk125MHz = 1'b0;
      forever begin
         #4 clk125MHz = ~clk125MHz;
      end
   end

   //--------------------------------------------------
   // watchdog
   //--------------------------------------------------

   always @(posedge clk125MHz) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   // every row costs its bytes, its gap and one full register sweep
   function automatic int cycle_budget();
      int total;
      total = 100;
      for (int r = 0; r < n_rows; r++) begin
         total = total + int'(rows[r].len) + int'(rows[r].gap) + reads_per_chk * 8;
      end
      // the closing section adds a held read, an unmapped read, two writes and two sweeps
      total = total + 20 + 8 + 2 * 8 + 2 * reads_per_chk * 8;
      return total;
   endfunction

   //--------------------------------------------------
   // byte stream and reference model
   //--------------------------------------------------

   task automatic send_frame(input frame_row_t row);
      logic [7:0] b;
      int         len;
      len = int'(row.len);
      for (int p = 0; p < len; p++) begin
         b = 8'($urandom);
         if (p == int'(hdr_a_pos)) begin
            b = (row.hdr == 2'd1) ? (hdr_a_val ^ 8'hff) : hdr_a_val;
         end
         if (p == int'(hdr_b_pos)) begin
            b = (row.hdr == 2'd2) ? (hdr_b_val ^ 8'hff) : hdr_b_val;
         end
         if (p == idx_off) begin
            b = row.index[23:16];
         end
         if (p == idx_off + 1) begin
            b = row.index[15:8];
         end
         if (p == idx_off + 2) begin
            b = row.index[7:0];
         end
         rx_en   = 1'b1;
         rx_data = b;
         @(posedge clk125MHz);
         #1;
      end
      rx_en   = 1'b0;
      rx_data = 8'd0;
      repeat (int'(row.gap)) begin
         @(posedge clk125MHz);
         #1;
      end
   endtask

   task automatic apply_model(input frame_row_t row);
      logic good;
      good = (row.hdr == 2'd0) && (int'(row.len) >= idx_off + 3);
      if (!good) begin
         exp_hdr_err = exp_hdr_err + 32'd1;
      end else if (!exp_started) begin
         if (row.index == 24'd0) begin
            exp_started = 1'b1;
            exp_prev    = row.index;
         end
      end else if (!exp_finished) begin
         exp_frames = exp_frames + 32'd1;
         if (row.index == exp_prev + 24'd1) begin
            exp_seq_ok = exp_seq_ok + 32'd1;
         end else begin
            exp_seq_err = exp_seq_err + 32'd1;
         end
         exp_prev = row.index;
         if (row.index == 24'(idx_final)) begin
            exp_finished = 1'b1;
         end
      end
   endtask

   task automatic clear_model();
      exp_started  = 1'b0;
      exp_finished = 1'b0;
      exp_prev     = 24'd0;
      exp_frames   = 32'd0;
      exp_seq_ok   = 32'd0;
      exp_seq_err  = 32'd0;
      exp_hdr_err  = 32'd0;
   endtask

   //--------------------------------------------------
   // AXI4-Lite master
   //--------------------------------------------------

   task automatic axi_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready) begin
         @(posedge clk125MHz);
         #1;
      end
      @(posedge clk125MHz);
      #1;
      arvalid = 1'b0;
      araddr  = 8'd0;
      while (!rvalid) begin
         @(posedge clk125MHz);
         #1;
      end
      repeat (hold) begin
         @(posedge clk125MHz);
         #1;
         assert (rvalid) else begin
            errors++;
            $display("read response dropped while rready was low");
         end
         assert (!arready) else begin
            errors++;
            $display("read address accepted while a response was pending");
         end
      end
      data = rdata;
      assert (rresp == 2'b00) else begin
         errors++;
         $display("read response code was not OKAY");
      end
      rready = 1'b1;
      @(posedge clk125MHz);
      #1;
      rready = 1'b0;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!(awready && wready)) begin
         @(posedge clk125MHz);
         #1;
      end
      @(posedge clk125MHz);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      while (!bvalid) begin
         @(posedge clk125MHz);
         #1;
      end
      assert (bresp == 2'b00) else begin
         errors++;
         $display("write response code was not OKAY");
      end
      @(posedge clk125MHz);
      #1;
      bready = 1'b0;
   endtask

   //--------------------------------------------------
   // checks
   //--------------------------------------------------

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      end
   endtask

   task automatic check_registers(input string tag);
      logic [31:0] val;
      axi_read(reg_status, 0, val);
      check_value({tag, " status"}, {30'd0, exp_finished, exp_started}, val);
      axi_read(reg_frames, 0, val);
      check_value({tag, " frames"}, exp_frames, val);
      axi_read(reg_seq_ok, 0, val);
      check_value({tag, " seq_ok"}, exp_seq_ok, val);
      axi_read(reg_seq_err, 0, val);
      check_value({tag, " seq_err"}, exp_seq_err, val);
      axi_read(reg_hdr_err, 0, val);
      check_value({tag, " hdr_err"}, exp_hdr_err, val);
   endtask

   //--------------------------------------------------
   // main sequence
   //--------------------------------------------------

   initial begin
      logic [31:0] val;
      rst         = 1'b1;
      rx_en       = 1'b0;
      rx_data     = 8'd0;
      awaddr      = 8'd0;
      awvalid     = 1'b0;
      wdata       = 32'd0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = 8'd0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      cycle_limit = cycle_budget();
      void'($urandom(32'h21e3));
      clear_model();

      repeat (4) @(posedge clk125MHz);
      #1;
      rst = 1'b0;
      @(posedge clk125MHz);
      #1;

      for (int r = 0; r < n_rows; r++) begin
         send_frame(rows[r]);
         apply_model(rows[r]);
         check_registers($sformatf("row %0d", r));
      end

      // hold the read response for several cycles before accepting it
      axi_read(reg_frames, 6, val);
      check_value("held read frames", exp_frames, val);

      axi_read(8'h20, 0, val);
      check_value("unmapped read", 32'd0, val);

      // a control write without bit 0 leaves the counters alone
      axi_write(reg_ctrl, 32'h0000_0002);
      check_registers("ctrl write without clear");

      axi_write(reg_ctrl, 32'h0000_0001);
      clear_model();
      check_registers("after clear");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
hw/seqmon_pkg.sv
hw/frame_parser.sv
hw/seq_checker.sv
hw/stats_regs.sv
hw/seqmon_top.sv
verif/seqmon_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sequence-loss monitor testbench with Verilator.
# Run from the project root. Exit status is 0 only when the pass message is in the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -f "$log"

verilator --binary --timing --assert -f build.f --top-module seqmon_tb \
   --Mdir obj_dir -o seqmon_sim > build.log 2>&1 \
   && ./obj_dir/seqmon_sim > "$log" 2>&1 \
   || { echo "build or simulation error, see build.log and $log"; }

cat "$log" 2>/dev/null

grep -q "Test completed successfully" "$log" 2>/dev/null \
   && { echo "PASS"; exit 0; } \
   || { echo "FAIL"; exit 1; }
